//--- list.f
+incdir+include
rtl/servo_bus_pkg.sv
rtl/servo_ctrl_pkg.sv
rtl/servo_regs.sv
rtl/servo_frame_timer.sv
rtl/servo_channel.sv
rtl/servo_status.sv
rtl/servo_top.sv
bench/servo_checker.sv
bench/servo_tb.sv

//--- bench/servo_tb.sv
// bench top; periods stay at or below MAX_PERIOD and requests come with one idle cycle between them
`default_nettype none

`include "servo_config.svh"

module servo_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RESET_CYCLES   = 10;
    localparam int MAX_PERIOD     = 400;
    localparam int NUM_REGS       = `SERVO_REG_ON_TIME + `SERVO_CHANNELS;
    localparam logic [`SERVO_ADDR_W-1:0] BASE = `SERVO_BASE;

    logic                       clk = 1'b0;
    logic                       reset;
    servo_bus_pkg::bus_req_t    bus_req;
    servo_bus_pkg::bus_rsp_t    bus_rsp;
    logic [`SERVO_CHANNELS-1:0] servo_pwm;
    int                         seed = 52;
    int                         cycles = 0;
    int                         err_count;

    // 4 ns clock
    always #2 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    servo_top u_servo_top (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .servo_pwm (servo_pwm)
    );

    servo_checker #(.MAX_PERIOD(MAX_PERIOD)) u_checker (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .servo_pwm (servo_pwm),
        .err_count (err_count)
    );

    //////////////////////////////
    // bus tasks
    //////////////////////////////

    // one-cycle strobe, then back to idle
    task automatic issue_request(input servo_bus_pkg::bus_op_e op,
                                 input logic [`SERVO_ADDR_W-1:0] addr,
                                 input logic [`SERVO_DATA_W-1:0] data);
        @(posedge clk);
        bus_req.strobe <= 1'b1;
        bus_req.op     <= op;
        bus_req.addr   <= addr;
        bus_req.wdata  <= data;
        @(posedge clk);
        bus_req.strobe <= 1'b0;
    endtask

    task automatic write_reg(input int offset, input logic [`SERVO_DATA_W-1:0] data);
        issue_request(servo_bus_pkg::BUS_WRITE, BASE + offset, data);
    endtask

    task automatic read_reg(input int offset);
        issue_request(servo_bus_pkg::BUS_READ, BASE + offset, '0);
    endtask

    task automatic read_all();
        for (int i = 0; i < NUM_REGS; i++) read_reg(i);
    endtask

    // period, then on-times, then the config word that starts the frames
    task automatic program_servo(input int period, input int on0, input int on1,
                                 input int on2, input int on3, input logic [31:0] cfg);
        write_reg(`SERVO_REG_PERIOD, period);
        write_reg(`SERVO_REG_ON_TIME + 0, on0);
        write_reg(`SERVO_REG_ON_TIME + 1, on1);
        write_reg(`SERVO_REG_ON_TIME + 2, on2);
        write_reg(`SERVO_REG_ON_TIME + 3, on3);
        write_reg(`SERVO_REG_CONFIG, cfg);
    endtask

    // enough for a held timer count plus the given number of frames
    task automatic wait_frames(input int period, input int frames);
        repeat (MAX_PERIOD + frames * (period + 1) + 20) @(posedge clk);
    endtask

    initial begin
        int per;
        int on [4];
        reset   = 1'b0;
        bus_req = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
        // reset values and read timing
        read_all();
        // readback, out-of-range requests, enable clearing
        program_servo(100, 10, 20, 30, 40, 32'h0000_000F);
        read_all();
        write_reg(`SERVO_REG_CONFIG, 32'h8000_000F);
        write_reg(`SERVO_REG_ON_TIME + 3, 40);
        read_reg(`SERVO_REG_CONFIG);
        issue_request(servo_bus_pkg::BUS_READ, BASE - 1, '0);
        issue_request(servo_bus_pkg::BUS_READ, BASE + NUM_REGS, '0);
        issue_request(servo_bus_pkg::BUS_WRITE, BASE - 1, 32'hFFFF_FFFF);
        issue_request(servo_bus_pkg::BUS_READ, 8'hFF, '0);
        read_all();
        // directed pulses
        write_reg(`SERVO_REG_CONFIG, 32'h8000_000F);
        wait_frames(100, 4);
        // random periods and on-times below the period
        for (int r = 0; r < 3; r++) begin
            per = 100 + ($unsigned($random(seed)) % (MAX_PERIOD - 99));
            for (int ch = 0; ch < 4; ch++) on[ch] = 1 + ($unsigned($random(seed)) % (per - 1));
            program_servo(per, on[0], on[1], on[2], on[3], 32'h8000_000F);
            read_all();
            wait_frames(per, 3);
        end
        // channel 1 has zero on-time, channel 2 is disabled
        program_servo(60, 15, 0, 25, 35, 32'h8000_000B);
        wait_frames(60, 4);
        write_reg(`SERVO_REG_CONFIG, 32'h0000_000B);
        repeat (20) @(posedge clk);
        // channel 0 outlasts the frame
        program_servo(50, 80, 20, 20, 20, 32'h8000_000F);
        wait_frames(50, 3);
        read_reg(`SERVO_REG_STATUS);
        write_reg(`SERVO_REG_STATUS, 32'h1);
        read_reg(`SERVO_REG_STATUS);
        wait_frames(50, 3);
        read_reg(`SERVO_REG_STATUS);
        write_reg(`SERVO_REG_CONFIG, 32'h0000_000F);
        repeat (10) @(posedge clk);
        write_reg(`SERVO_REG_STATUS, 32'hF);
        read_reg(`SERVO_REG_STATUS);
        repeat (20) @(posedge clk);
        u_checker.print_counts();
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // run limit
    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/servo_checker.sv
// passive checker; MAX_PERIOD must cover every period the bench writes, status bits may be unknown near changes
`default_nettype none

`include "servo_config.svh"

module servo_checker #(
    parameter int MAX_PERIOD = 400
) (
    input  logic                       clk,
    input  logic                       reset,
    input  servo_bus_pkg::bus_req_t    bus_req,
    input  servo_bus_pkg::bus_rsp_t    bus_rsp,
    input  logic [`SERVO_CHANNELS-1:0] servo_pwm,
    output int                         err_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NCH      = `SERVO_CHANNELS;
    localparam int NUM_REGS = `SERVO_REG_ON_TIME + `SERVO_CHANNELS;

    // what one channel should do under the current settings
    typedef struct packed {
        logic                     active;
        logic                     overrun;
        logic [`SERVO_DATA_W-1:0] width;
    } pulse_exp_t;

    // register model, built from observed writes
    logic [`SERVO_DATA_W-1:0] m_period;
    logic [`SERVO_DATA_W-1:0] m_config;
    logic [`SERVO_DATA_W-1:0] m_on_time [NCH];
    // pending read response
    logic                     rd_pend;
    logic                     rd_status;
    logic [`SERVO_DATA_W-1:0] rd_exp;
    logic [`SERVO_DATA_W-1:0] rd_mask;
    // per-channel pin tracking
    logic prev_pin [NCH];
    logic rise_ok [NCH];
    logic last_ok [NCH];
    logic ovr_may [NCH];
    int   rise_cyc [NCH];
    int   last_rise [NCH];
    int   quiet [NCH];
    int   ovr_age [NCH];
    int   cyc;
    int   block_until;
    int   checks = 0;
    int   bus_errs = 0;
    int   pin_errs = 0;
    int   status_errs = 0;

    assign err_count = bus_errs + pin_errs + status_errs;

    //////////////////////////////
    // reference model
    //////////////////////////////

    // pulse is on-time cycles per frame; a frame is period plus one cycles
    function automatic pulse_exp_t expected_pulse(input logic [`SERVO_DATA_W-1:0] period,
                                                  input logic [`SERVO_DATA_W-1:0] on_time,
                                                  input logic chan_en, input logic glob_en);
        pulse_exp_t e;
        e.active  = glob_en && chan_en && (on_time != 0);
        // still high when the next tick comes
        e.overrun = e.active && (on_time > period);
        e.width   = e.active ? on_time : '0;
        return e;
    endfunction

    function automatic pulse_exp_t chan_exp(input int ch);
        return expected_pulse(m_period, m_on_time[ch], m_config[ch],
                              m_config[`SERVO_GLOBAL_EN_BIT]);
    endfunction

    // overrun part of the expectation for one channel
    function automatic logic overrun_expected(input int ch);
        pulse_exp_t e;
        e = chan_exp(ch);
        return e.overrun;
    endfunction

    // worst case wait for a held timer count, then two full frames
    function automatic int ovr_settle();
        return MAX_PERIOD + 2 * (int'(m_period) + 1) + 8;
    endfunction

    task automatic print_counts();
        $display("checks %0d, bus errors %0d, pin errors %0d, status errors %0d",
                 checks, bus_errs, pin_errs, status_errs);
    endtask

    // anything in flight is no longer comparable after a timing or enable change
    task automatic invalidate_pulses();
        block_until = cyc + 3;
        for (int ch = 0; ch < NCH; ch++) begin
            rise_ok[ch] = 1'b0;
            last_ok[ch] = 1'b0;
            quiet[ch]   = 0;
            ovr_age[ch] = 0;
        end
    endtask

    task automatic reset_model();
        m_period    = '0;
        m_config    = '0;
        rd_pend     = 1'b0;
        rd_status   = 1'b0;
        cyc         = 0;
        block_until = 0;
        for (int ch = 0; ch < NCH; ch++) begin
            m_on_time[ch] = '0;
            prev_pin[ch]  = 1'b0;
            rise_ok[ch]   = 1'b0;
            last_ok[ch]   = 1'b0;
            ovr_may[ch]   = 1'b0;
            quiet[ch]     = 0;
            ovr_age[ch]   = 0;
        end
    endtask

    //////////////////////////////
    // bus side
    //////////////////////////////

    // rvalid must follow an in-range read by exactly one cycle, never otherwise
    task automatic check_response();
        if (bus_rsp.rvalid !== rd_pend) begin
            bus_errs++;
            $display("ERR %0t: read-valid is %b, expected %b", $time, bus_rsp.rvalid, rd_pend);
        end else if (rd_pend && (((bus_rsp.rdata ^ rd_exp) & rd_mask) !== '0)) begin
            if (rd_status) status_errs++;
            else bus_errs++;
            $display("ERR %0t: read data %h, expected %h under mask %h",
                     $time, bus_rsp.rdata, rd_exp, rd_mask);
        end
        if (rd_pend) checks++;
    endtask

    task automatic handle_request();
        int  a;
        int  off;
        logic hit;
        a   = int'(bus_req.addr);
        off = a - `SERVO_BASE;
        hit = bus_req.strobe && (a >= `SERVO_BASE) && (a < `SERVO_BASE + NUM_REGS);
        rd_pend   = hit && (bus_req.op == servo_bus_pkg::BUS_READ);
        rd_status = rd_pend && (off == `SERVO_REG_STATUS);
        rd_exp    = '0;
        rd_mask   = '1;
        if (rd_pend) begin
            if (off == `SERVO_REG_PERIOD) rd_exp = m_period;
            else if (off == `SERVO_REG_CONFIG) rd_exp = m_config;
            else if (off >= `SERVO_REG_ON_TIME) rd_exp = m_on_time[off - `SERVO_REG_ON_TIME];
            else begin
                // settled overrun must show, never-overrun must not, the rest is open
                for (int ch = 0; ch < NCH; ch++) begin
                    if (overrun_expected(ch) && ovr_age[ch] > ovr_settle()) rd_exp[ch] = 1'b1;
                    else if (ovr_may[ch]) rd_mask[ch] = 1'b0;
                end
            end
        end
        if (hit && bus_req.op == servo_bus_pkg::BUS_WRITE) begin
            if (off == `SERVO_REG_STATUS) begin
                for (int ch = 0; ch < NCH; ch++) begin
                    if (bus_req.wdata[ch]) begin
                        ovr_age[ch] = 0;
                        if (!overrun_expected(ch)) ovr_may[ch] = 1'b0;
                    end
                end
            end else begin
                if (off == `SERVO_REG_PERIOD) m_period = bus_req.wdata;
                else if (off == `SERVO_REG_CONFIG) m_config = bus_req.wdata;
                else m_on_time[off - `SERVO_REG_ON_TIME] = bus_req.wdata;
                // timing writes drop the global enable
                if (off != `SERVO_REG_CONFIG) m_config[`SERVO_GLOBAL_EN_BIT] = 1'b0;
                invalidate_pulses();
            end
        end
    endtask

    //////////////////////////////
    // pin side
    //////////////////////////////

    task automatic check_pins();
        pulse_exp_t e;
        logic       pin;
        for (int ch = 0; ch < NCH; ch++) begin
            e   = chan_exp(ch);
            pin = servo_pwm[ch];
            if (cyc >= block_until && !e.active && pin) begin
                pin_errs++;
                $display("ERR %0t: pin %0d high while channel inactive", $time, ch);
            end
            if (e.overrun && ovr_age[ch] > ovr_settle() && !pin) begin
                pin_errs++;
                $display("ERR %0t: pin %0d low during overrun", $time, ch);
            end
            if (pin && !prev_pin[ch]) begin
                if (cyc >= block_until && e.active) begin
                    if (last_ok[ch]) begin
                        checks++;
                        if (cyc - last_rise[ch] != int'(m_period) + 1) begin
                            pin_errs++;
                            $display("ERR %0t: pin %0d rises %0d cycles apart, expected %0d",
                                     $time, ch, cyc - last_rise[ch], int'(m_period) + 1);
                        end
                    end
                    rise_ok[ch]   = 1'b1;
                    last_ok[ch]   = 1'b1;
                    rise_cyc[ch]  = cyc;
                    last_rise[ch] = cyc;
                end else begin
                    rise_ok[ch] = 1'b0;
                    last_ok[ch] = 1'b0;
                end
                quiet[ch] = 0;
            end
            if (!pin && prev_pin[ch] && rise_ok[ch]) begin
                checks++;
                if (e.overrun || (cyc - rise_cyc[ch] != int'(e.width))) begin
                    pin_errs++;
                    $display("ERR %0t: pin %0d high for %0d cycles, expected %0d",
                             $time, ch, cyc - rise_cyc[ch], int'(e.width));
                end
                rise_ok[ch] = 1'b0;
            end
            // an active channel must pulse at least once per frame
            if (e.active && !e.overrun && cyc >= block_until) quiet[ch]++;
            else quiet[ch] = 0;
            if (quiet[ch] > MAX_PERIOD + int'(m_period) + 8) begin
                pin_errs++;
                $display("ERR %0t: pin %0d produced no pulse", $time, ch);
                quiet[ch] = 0;
            end
            prev_pin[ch] = pin;
        end
    endtask

    // sampled values are the ones settled before this edge
    always @(posedge clk) begin
        if (!reset) begin
            reset_model();
        end else begin
            check_response();
            check_pins();
            handle_request();
            for (int ch = 0; ch < NCH; ch++) begin
                if (overrun_expected(ch)) begin
                    ovr_age[ch]++;
                    ovr_may[ch] = 1'b1;
                end else begin
                    ovr_age[ch] = 0;
                end
            end
            cyc++;
        end
    end

endmodule

`default_nettype wire

//--- rtl/servo_top.sv
// pins rise two cycles after a frame tick; a timing write stops all channels until re-enabled
`default_nettype none

`include "servo_config.svh"

module servo_top (
    input  logic                       clk,
    input  logic                       reset,
    input  servo_bus_pkg::bus_req_t    bus_req,
    output servo_bus_pkg::bus_rsp_t    bus_rsp,
    output logic [`SERVO_CHANNELS-1:0] servo_pwm
);

    logic [`SERVO_DATA_W-1:0]                        period;
    logic                                            global_en;
    logic                                            frame_tick;
    servo_ctrl_pkg::chan_set_t [`SERVO_CHANNELS-1:0]  chan_set;
    servo_ctrl_pkg::chan_stat_t [`SERVO_CHANNELS-1:0] chan_stat;
    logic [`SERVO_CHANNELS-1:0]                      status_clear;
    logic [`SERVO_CHANNELS-1:0]                      overrun;

    //////////////////////////////
    // register block
    //////////////////////////////

    servo_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .period       (period),
        .global_en    (global_en),
        .chan_set     (chan_set),
        .status_clear (status_clear),
        .overrun      (overrun)
    );

    // shared frame tick for all channels
    servo_frame_timer u_frame_timer (
        .clk        (clk),
        .reset      (reset),
        .period     (period),
        .global_en  (global_en),
        .frame_tick (frame_tick)
    );

    //////////////////////////////
    // channels
    //////////////////////////////

    for (genvar i = 0; i < `SERVO_CHANNELS; i++) begin : g_chan
        servo_channel u_channel (
            .clk        (clk),
            .reset      (reset),
            .frame_tick (frame_tick),
            .global_en  (global_en),
            .chan_set   (chan_set[i]),
            .chan_stat  (chan_stat[i])
        );
    end

    // pins and sticky flags
    servo_status u_status (
        .clk          (clk),
        .reset        (reset),
        .chan_stat    (chan_stat),
        .status_clear (status_clear),
        .servo_pwm    (servo_pwm),
        .overrun      (overrun)
    );

endmodule

`default_nettype wire

//--- rtl/servo_status.sv
// pins lag channel levels by one cycle; a flag set and its clear in one cycle leave the flag set
`default_nettype none

`include "servo_config.svh"

module servo_status (
    input  logic                                            clk,
    input  logic                                            reset,
    input  servo_ctrl_pkg::chan_stat_t [`SERVO_CHANNELS-1:0] chan_stat,
    input  logic [`SERVO_CHANNELS-1:0]                      status_clear,
    output logic [`SERVO_CHANNELS-1:0]                      servo_pwm,
    output logic [`SERVO_CHANNELS-1:0]                      overrun
);

    logic [`SERVO_CHANNELS-1:0] level;
    logic [`SERVO_CHANNELS-1:0] overrun_evt;

    // unpack the per-channel words into vectors
    always_comb begin
        for (int i = 0; i < `SERVO_CHANNELS; i++) begin
            level[i]       = chan_stat[i].level;
            overrun_evt[i] = chan_stat[i].overrun;
        end
    end

    //////////////////////////////
    // output pins
    //////////////////////////////

    // registered so the pins come straight from flops
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            servo_pwm <= '0;
        end else begin
            servo_pwm <= level;
        end
    end

    //////////////////////////////
    // sticky overrun flags
    //////////////////////////////

    // clear first, then set, so a fresh event survives a clear
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            overrun <= '0;
        end else begin
            overrun <= (overrun & ~status_clear) | overrun_evt;
        end
    end

endmodule

`default_nettype wire

//--- rtl/servo_channel.sv
// one channel; on-time is sampled at the frame tick, so changes apply from the next frame
`default_nettype none

`include "servo_config.svh"

module servo_channel (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       frame_tick,
    input  logic                       global_en,
    input  servo_ctrl_pkg::chan_set_t  chan_set,
    output servo_ctrl_pkg::chan_stat_t chan_stat
);

    servo_ctrl_pkg::chan_state_e state;
    logic [`SERVO_DATA_W-1:0]    count;
    logic                        overrun_q;
    logic                        run_en;
    logic                        start;

    // channel runs only with both enables
    assign run_en = global_en && chan_set.enable;
    // zero on-time means no pulse at all
    assign start  = frame_tick && (chan_set.on_time != '0);

    //////////////////////////////
    // channel FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= servo_ctrl_pkg::CH_IDLE;
            count     <= '0;
            overrun_q <= 1'b0;
        end else if (!run_en) begin
            // disable drops the level at the next edge
            state     <= servo_ctrl_pkg::CH_IDLE;
            count     <= '0;
            overrun_q <= 1'b0;
        end else begin
            overrun_q <= 1'b0;
            case (state)
                servo_ctrl_pkg::CH_HIGH: begin
                    if (frame_tick) begin
                        // new frame before the pulse ended
                        overrun_q <= 1'b1;
                        if (start) begin
                            count <= chan_set.on_time;
                        end else begin
                            state <= servo_ctrl_pkg::CH_LOW;
                        end
                    end else if (count == 1) begin
                        // last high cycle
                        state <= servo_ctrl_pkg::CH_LOW;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    // idle or low, wait for the tick
                    if (start) begin
                        state <= servo_ctrl_pkg::CH_HIGH;
                        count <= chan_set.on_time;
                    end else begin
                        state <= servo_ctrl_pkg::CH_LOW;
                    end
                end
            endcase
        end
    end

    // level is high for exactly on-time cycles per frame
    always_comb begin
        chan_stat.level   = (state == servo_ctrl_pkg::CH_HIGH);
        chan_stat.overrun = overrun_q;
    end

endmodule

`default_nettype wire

//--- rtl/servo_frame_timer.sv
// ticks are period plus one cycles apart; the count holds while disabled and resumes from there
`default_nettype none

`include "servo_config.svh"

module servo_frame_timer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`SERVO_DATA_W-1:0] period,
    input  logic                     global_en,
    output logic                     frame_tick
);

    logic [`SERVO_DATA_W-1:0] count;
    logic                     at_zero;

    assign at_zero = (count == '0);

    //////////////////////////////
    // period down-counter
    //////////////////////////////

    // counts period, period-1 .. 0 then reloads
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (global_en) begin
            if (at_zero) begin
                count <= period;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    //////////////////////////////
    // frame tick
    //////////////////////////////

    // first tick comes right after enable when the count sits at zero
    // held non-zero count delays it instead
    assign frame_tick = global_en && at_zero;

endmodule

`default_nettype wire

//--- rtl/servo_regs.sv
// word registers only; out-of-range requests are dropped silently and partial writes are not supported
`default_nettype none

`include "servo_config.svh"

module servo_regs (
    input  logic                                            clk,
    input  logic                                            reset,
    input  servo_bus_pkg::bus_req_t                         bus_req,
    output servo_bus_pkg::bus_rsp_t                         bus_rsp,
    output logic [`SERVO_DATA_W-1:0]                        period,
    output logic                                            global_en,
    output servo_ctrl_pkg::chan_set_t [`SERVO_CHANNELS-1:0] chan_set,
    output logic [`SERVO_CHANNELS-1:0]                      status_clear,
    input  logic [`SERVO_CHANNELS-1:0]                      overrun
);

    // registers in the block, on-times last
    localparam int NUM_REGS = `SERVO_REG_ON_TIME + `SERVO_CHANNELS;
    localparam logic [`SERVO_ADDR_W-1:0] BASE_ADDR = `SERVO_BASE;

    logic [`SERVO_ADDR_W-1:0] offset;
    logic                     hit;
    logic                     wr_en;
    logic                     rd_en;
    logic                     timing_wr;
    logic [`SERVO_DATA_W-1:0] period_q;
    logic [`SERVO_DATA_W-1:0] config_q;
    logic [`SERVO_DATA_W-1:0] rd_word;
    logic [`SERVO_DATA_W-1:0] on_time_q [`SERVO_CHANNELS];

    //////////////////////////////
    // address decode
    //////////////////////////////

    // single compare against the base, everything below works on the offset
    assign offset = bus_req.addr - BASE_ADDR;
    assign hit    = bus_req.strobe && (bus_req.addr >= BASE_ADDR) && (offset < NUM_REGS);
    assign wr_en  = hit && (bus_req.op == servo_bus_pkg::BUS_WRITE);
    assign rd_en  = hit && (bus_req.op == servo_bus_pkg::BUS_READ);

    // period or any on-time changes the frame timing
    assign timing_wr = wr_en &&
        ((offset == `SERVO_REG_PERIOD) || (offset >= `SERVO_REG_ON_TIME));

    //////////////////////////////
    // register file
    //////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            period_q <= '0;
            config_q <= '0;
            for (int i = 0; i < `SERVO_CHANNELS; i++) begin
                on_time_q[i] <= '0;
            end
        end else begin
            if (wr_en && (offset == `SERVO_REG_PERIOD)) begin
                period_q <= bus_req.wdata;
            end
            if (wr_en && (offset == `SERVO_REG_CONFIG)) begin
                config_q <= bus_req.wdata;
            end
            for (int i = 0; i < `SERVO_CHANNELS; i++) begin
                if (wr_en && (offset == `SERVO_REG_ON_TIME + i)) begin
                    on_time_q[i] <= bus_req.wdata;
                end
            end
            // stop the outputs until software re-enables with the new timing
            if (timing_wr) begin
                config_q[`SERVO_GLOBAL_EN_BIT] <= 1'b0;
            end
        end
    end

    // write-one-to-clear of the sticky flags, applied at the same edge
    assign status_clear = (wr_en && (offset == `SERVO_REG_STATUS)) ?
                          bus_req.wdata[`SERVO_CHANNELS-1:0] : '0;

    //////////////////////////////
    // readback
    //////////////////////////////

    always_comb begin
        rd_word = '0;
        case (offset)
            `SERVO_REG_PERIOD: rd_word = period_q;
            `SERVO_REG_CONFIG: rd_word = config_q;
            // status shows the flags, upper bits read zero
            `SERVO_REG_STATUS: rd_word[`SERVO_CHANNELS-1:0] = overrun;
            default: begin
                for (int i = 0; i < `SERVO_CHANNELS; i++) begin
                    if (offset == `SERVO_REG_ON_TIME + i) begin
                        rd_word = on_time_q[i];
                    end
                end
            end
        endcase
    end

    // response one cycle after the read strobe
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bus_rsp <= '0;
        end else begin
            bus_rsp.rvalid <= rd_en;
            if (rd_en) begin
                bus_rsp.rdata <= rd_word;
            end
        end
    end

    //////////////////////////////
    // outputs to the control path
    //////////////////////////////

    assign period    = period_q;
    assign global_en = config_q[`SERVO_GLOBAL_EN_BIT];

    always_comb begin
        for (int i = 0; i < `SERVO_CHANNELS; i++) begin
            chan_set[i].enable  = config_q[i];
            chan_set[i].on_time = on_time_q[i];
        end
    end

endmodule

`default_nettype wire

//--- rtl/servo_ctrl_pkg.sv
// control path types only; on-times share the register data width
`default_nettype none

`include "servo_config.svh"

package servo_ctrl_pkg;

    //////////////////////////////
    // channel FSM
    //////////////////////////////

    // idle when disabled, low between pulses while enabled
    typedef enum logic [1:0] {
        CH_IDLE = 2'd0,
        CH_HIGH = 2'd1,
        CH_LOW  = 2'd2
    } chan_state_e;

    //////////////////////////////
    // per-channel words
    //////////////////////////////

    // settings from the register block to one channel
    typedef struct packed {
        logic                     enable;
        logic [`SERVO_DATA_W-1:0] on_time;
    } chan_set_t;

    // what one channel reports to the status collector
    // overrun is a single-cycle event, not a flag
    typedef struct packed {
        logic level;
        logic overrun;
    } chan_stat_t;

endpackage

`default_nettype wire

//--- rtl/servo_bus_pkg.sv
// bus types only; one request per cycle, no back-pressure, read data returns one cycle later
`default_nettype none

`include "servo_config.svh"

package servo_bus_pkg;

    //////////////////////////////
    // opcodes
    //////////////////////////////

    // direction of a single bus request
    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    //////////////////////////////
    // request and response words
    //////////////////////////////

    // one request word, valid only in the cycle where strobe is high
    typedef struct packed {
        logic                     strobe;
        bus_op_e                  op;
        logic [`SERVO_ADDR_W-1:0] addr;
        logic [`SERVO_DATA_W-1:0] wdata;
    } bus_req_t;

    // rvalid pulses for one cycle, rdata is meaningful only then
    typedef struct packed {
        logic                     rvalid;
        logic [`SERVO_DATA_W-1:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

//--- include/servo_config.svh
// build-time settings only; SERVO_BASE plus 3 plus SERVO_CHANNELS must fit in SERVO_ADDR_W bits
`ifndef SERVO_CONFIG_SVH
`define SERVO_CONFIG_SVH

//////////////////////////////
// sizes
//////////////////////////////

// number of servo channels, 1 to 16
`define SERVO_CHANNELS 4
// register and bus data width
`define SERVO_DATA_W 32
// bus word address width
`define SERVO_ADDR_W 8

//////////////////////////////
// register map
//////////////////////////////

// word address of the first register of the block
`define SERVO_BASE 'h20
// word offsets from the base
`define SERVO_REG_PERIOD 0
`define SERVO_REG_CONFIG 1
`define SERVO_REG_STATUS 2
// on-time of channel n sits at this offset plus n
`define SERVO_REG_ON_TIME 3
// global enable in the configuration word, channel enables in the low bits
`define SERVO_GLOBAL_EN_BIT 31

`endif
